//--- rtl/fwd_pkg.sv
// shared types and constants for the ipv4 forwarding stage
// imported by every rtl block and by the testbench
package fwd_pkg;

    ////////////////////////////////////////////////////////////
    // sizes

    localparam int NUM_PORTS     = 16;
    localparam int PORT_W        = $clog2(NUM_PORTS);
    // host cpu sits on port 0
    localparam int CPU_PORT      = 0;
    localparam int ROUTE_ENTRIES = 16;
    localparam int ROUTE_IDX_W   = $clog2(ROUTE_ENTRIES);
    localparam int CNT_W         = 16;
    // 16-bit words in a 20-byte header
    localparam int HDR_WORDS     = 10;

    // cycles from in_valid
    localparam int LOOKUP_LAT    = 1;
    localparam int VERIFY_LAT    = 2;
    localparam int PIPE_LAT      = 3;

    ////////////////////////////////////////////////////////////
    // types

    // wire order, word 0 in the top bits
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [7:0]  tos;
        logic [15:0] total_len;
        logic [15:0] ident;
        logic [15:0] flags_frag;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] checksum;
        logic [31:0] src_addr;
        logic [31:0] dst_addr;
    } ipv4_hdr_t;

    // item carried down the pipeline
    typedef struct packed {
        ipv4_hdr_t          hdr;
        logic [PORT_W-1:0]  ingress_port;
        logic [15:0]        byte_length;
    } pkt_desc_t;

    // prefix_len 0..32, 0 is the default route
    typedef struct packed {
        logic               valid;
        logic [31:0]        prefix;
        logic [5:0]         prefix_len;
        logic [PORT_W-1:0]  egress_port;
    } route_entry_t;

    typedef struct packed {
        logic               hit;
        logic [PORT_W-1:0]  egress_port;
    } route_result_t;

    typedef enum logic [1:0] {
        ACT_FORWARD = 2'd0,
        ACT_TO_CPU  = 2'd1,
        ACT_DROP    = 2'd2
    } fwd_action_t;

    // saturating counters, one per cause
    typedef struct packed {
        logic [CNT_W-1:0] bad_checksum;
        logic [CNT_W-1:0] ttl_expired;
        logic [CNT_W-1:0] no_route;
    } drop_counts_t;

endpackage

//--- rtl/stage_delay.sv
// valid plus payload shift register, aligns side data to a later pipeline stage
// payload type and depth are set per instance
`timescale 1ns/100ps

module stage_delay #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    logic [DEPTH-1:0] vld_q;
    payload_t         data_q [DEPTH];

    // valids only
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= in_valid;
            for (int i = 1; i < DEPTH; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    // payload shifts every cycle
    always_ff @(posedge clk) begin
        data_q[0] <= in_data;
        for (int i = 1; i < DEPTH; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    assign out_valid = vld_q[DEPTH-1];
    assign out_data  = data_q[DEPTH-1];

    a_out_valid_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(out_valid));

endmodule

//--- rtl/ipv4_checksum_verify.sv
// two-stage ipv4 header checksum check
// hdr_ok is high when the ten words sum to all ones, two cycles after in_valid
`timescale 1ns/100ps

module ipv4_checksum_verify (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  fwd_pkg::ipv4_hdr_t hdr,
    output logic              ok_valid,
    output logic              hdr_ok
);

    import fwd_pkg::*;

    // word 0 leftmost
    logic [0:HDR_WORDS-1][15:0] words;
    logic [18:0]                sum_a;
    logic [18:0]                sum_b;
    logic [15:0]                half_a_q;
    logic [15:0]                half_b_q;
    logic                       s1_valid_q;
    logic [16:0]                total;
    logic [15:0]                folded;

    // end-around carry down to 16 bits, two passes cover five words
    function automatic logic [15:0] fold19(input logic [18:0] s);
        logic [16:0] t;
        t = {1'b0, s[15:0]} + {14'd0, s[18:16]};
        return t[15:0] + {15'd0, t[16]};
    endfunction

    assign words = hdr;

    ////////////////////////////////////////////////////////////
    // stage one, two half sums

    always_comb begin
        sum_a = '0;
        sum_b = '0;
        for (int i = 0; i < HDR_WORDS / 2; i++) begin
            sum_a = sum_a + {3'd0, words[i]};
            sum_b = sum_b + {3'd0, words[i + HDR_WORDS / 2]};
        end
    end

    always_ff @(posedge clk) begin
        half_a_q <= fold19(sum_a);
        half_b_q <= fold19(sum_b);
    end

    ////////////////////////////////////////////////////////////
    // stage two, fold and compare

    assign total  = {1'b0, half_a_q} + {1'b0, half_b_q};
    // single carry can not overflow again
    assign folded = total[15:0] + {15'd0, total[16]};

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid_q <= 1'b0;
            ok_valid   <= 1'b0;
        end else begin
            s1_valid_q <= in_valid;
            ok_valid   <= s1_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        hdr_ok <= (folded == 16'hFFFF);
    end

endmodule

//--- rtl/ipv4_checksum_update.sv
// incremental checksum rewrite for a ttl decrement, one cycle
// follows HC' = ~(~HC + ~m + m') on the ttl/protocol word
`timescale 1ns/100ps

module ipv4_checksum_update (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  logic [15:0] old_checksum,
    input  logic [15:0] ttl_proto,
    output logic        upd_valid,
    output logic [15:0] new_checksum
);

    logic [15:0] hc_inv;
    logic [15:0] m_inv;
    // word after ttl - 1, protocol untouched
    logic [15:0] m_new;
    logic [17:0] raw_sum;
    logic [16:0] fold1;
    logic [15:0] fold2;

    assign hc_inv = ~old_checksum;
    assign m_inv  = ~ttl_proto;
    assign m_new  = ttl_proto - 16'h0100;

    // three terms, then end-around carry twice
    assign raw_sum = {2'b00, hc_inv} + {2'b00, m_inv} + {2'b00, m_new};
    assign fold1   = {1'b0, raw_sum[15:0]} + {15'd0, raw_sum[17:16]};
    assign fold2   = fold1[15:0] + {15'd0, fold1[16]};

    always_ff @(posedge clk) begin
        if (rst) begin
            upd_valid <= 1'b0;
        end else begin
            upd_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        new_checksum <= ~fold2;
    end

    // ttl 0 would wrap the high byte
    a_ttl_nonzero: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> (ttl_proto[15:8] != 8'd0));

endmodule

//--- rtl/route_table.sv
// 16-entry route table, written by strobe, longest-prefix lookup in one cycle
// a write is seen by lookups starting the next cycle
`timescale 1ns/100ps

module route_table (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cfg_wr,
    input  logic [fwd_pkg::ROUTE_IDX_W-1:0] cfg_index,
    input  fwd_pkg::route_entry_t           cfg_entry,
    input  logic                            lookup_valid,
    input  logic [31:0]                     dst_addr,
    output logic                            result_valid,
    output fwd_pkg::route_result_t          result
);

    import fwd_pkg::*;

    logic [ROUTE_ENTRIES-1:0] valid_q;
    route_entry_t             entry_q [ROUTE_ENTRIES];
    logic [ROUTE_ENTRIES-1:0] match;
    logic                     best_hit;
    logic [5:0]               best_len;
    logic [PORT_W-1:0]        best_port;

    // top len bits set, len 32 shifts all ones out
    function automatic logic [31:0] len_mask(input logic [5:0] len);
        return ~(32'hFFFF_FFFF >> len);
    endfunction

    ////////////////////////////////////////////////////////////
    // table storage

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (cfg_wr) begin
            valid_q[cfg_index] <= cfg_entry.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_wr) begin
            entry_q[cfg_index] <= cfg_entry;
        end
    end

    ////////////////////////////////////////////////////////////
    // parallel compare

    always_comb begin
        for (int i = 0; i < ROUTE_ENTRIES; i++) begin
            match[i] = valid_q[i] &&
                (((dst_addr ^ entry_q[i].prefix) & len_mask(entry_q[i].prefix_len)) == '0);
        end
    end

    // strict greater, so lowest index keeps a tie
    always_comb begin
        best_hit  = 1'b0;
        best_len  = '0;
        best_port = '0;
        for (int i = 0; i < ROUTE_ENTRIES; i++) begin
            if (match[i] && (!best_hit || (entry_q[i].prefix_len > best_len))) begin
                best_hit  = 1'b1;
                best_len  = entry_q[i].prefix_len;
                best_port = entry_q[i].egress_port;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // result register

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= lookup_valid;
        end
    end

    always_ff @(posedge clk) begin
        result.hit         <= best_hit;
        result.egress_port <= best_port;
    end

    // longer prefixes would never match
    a_prefix_len_range: assert property (@(posedge clk) disable iff (rst)
        cfg_wr |-> (cfg_entry.prefix_len <= 6'd32));

endmodule

//--- rtl/forward_ctrl.sv
// forwarding decision, output descriptor build and drop counters
// descriptor arrives one cycle before the verdicts and is staged here
`timescale 1ns/100ps

module forward_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       stage_valid,
    input  fwd_pkg::pkt_desc_t         desc,
    input  logic                       hdr_ok,
    input  fwd_pkg::route_result_t     route,
    input  logic [15:0]                new_checksum,
    output logic                       out_valid,
    output fwd_pkg::pkt_desc_t         out_desc,
    output fwd_pkg::fwd_action_t       out_action,
    output logic [fwd_pkg::PORT_W-1:0] out_egress_port,
    output fwd_pkg::drop_counts_t      drop_counts
);

    import fwd_pkg::*;

    logic              s2_valid;
    pkt_desc_t         s2_desc;
    logic              ttl_low;
    fwd_action_t       act;
    logic [PORT_W-1:0] port;
    pkt_desc_t         nxt_desc;
    logic              cnt_bad;
    logic              cnt_ttl;
    logic              cnt_route;

    // hold at max
    function automatic logic [CNT_W-1:0] sat_inc(input logic [CNT_W-1:0] c);
        return (&c) ? c : c + 1'b1;
    endfunction

    ////////////////////////////////////////////////////////////
    // descriptor stage, lines up with checksum and route

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= stage_valid;
        end
    end

    always_ff @(posedge clk) begin
        s2_desc <= desc;
    end

    ////////////////////////////////////////////////////////////
    // decision, priority order

    assign ttl_low = (s2_desc.hdr.ttl <= 8'd1);

    always_comb begin
        act      = ACT_FORWARD;
        port     = route.egress_port;
        nxt_desc = s2_desc;
        if (!hdr_ok) begin
            act  = ACT_DROP;
            port = '0;
        end else if (ttl_low) begin
            // punt to host, header as received
            act  = ACT_TO_CPU;
            port = PORT_W'(CPU_PORT);
        end else if (!route.hit) begin
            act  = ACT_DROP;
            port = '0;
        end else begin
            nxt_desc.hdr.ttl      = s2_desc.hdr.ttl - 8'd1;
            nxt_desc.hdr.checksum = new_checksum;
        end
    end

    // one cause per item at most
    assign cnt_bad   = s2_valid && !hdr_ok;
    assign cnt_ttl   = s2_valid && hdr_ok && ttl_low;
    assign cnt_route = s2_valid && hdr_ok && !ttl_low && !route.hit;

    ////////////////////////////////////////////////////////////
    // output and counter registers

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid   <= 1'b0;
            drop_counts <= '0;
        end else begin
            out_valid <= s2_valid;
            if (cnt_bad) begin
                drop_counts.bad_checksum <= sat_inc(drop_counts.bad_checksum);
            end
            if (cnt_ttl) begin
                drop_counts.ttl_expired <= sat_inc(drop_counts.ttl_expired);
            end
            if (cnt_route) begin
                drop_counts.no_route <= sat_inc(drop_counts.no_route);
            end
        end
    end

    always_ff @(posedge clk) begin
        out_desc        <= nxt_desc;
        out_action      <= act;
        out_egress_port <= port;
    end

    // verdicts must belong to the staged item
    a_verdicts_in_step: assert property (@(posedge clk) disable iff (rst)
        s2_valid |-> !$isunknown({hdr_ok, route.hit}));

    a_update_in_step: assert property (@(posedge clk) disable iff (rst)
        (s2_valid && hdr_ok && !ttl_low && route.hit) |-> !$isunknown(new_checksum));

endmodule

//--- rtl/ipv4_forward_top.sv
// ipv4 forwarding stage top, fixed 3-cycle latency from in_valid to out_valid
// lookup and checksum check start at cycle 0, ttl update at cycle 1
`timescale 1ns/100ps

module ipv4_forward_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            in_valid,
    input  fwd_pkg::pkt_desc_t              in_desc,
    input  logic                            cfg_wr,
    input  logic [fwd_pkg::ROUTE_IDX_W-1:0] cfg_index,
    input  fwd_pkg::route_entry_t           cfg_entry,
    output logic                            out_valid,
    output fwd_pkg::pkt_desc_t              out_desc,
    output fwd_pkg::fwd_action_t            out_action,
    output logic [fwd_pkg::PORT_W-1:0]      out_egress_port,
    output fwd_pkg::drop_counts_t           drop_counts
);

    import fwd_pkg::*;

    logic          lookup_vld;
    route_result_t lookup_res;
    logic          res_vld;
    route_result_t res_q;
    logic          ok_vld;
    logic          hdr_ok;
    logic          desc_vld;
    pkt_desc_t     desc_q;
    logic          upd_req;
    logic          upd_vld;
    logic [15:0]   new_checksum;

    ////////////////////////////////////////////////////////////
    // cycle 0 to 2, lookup and checksum check

    route_table route_table0 (
        .clk          ( clk                 ),
        .rst          ( rst                 ),
        .cfg_wr       ( cfg_wr              ),
        .cfg_index    ( cfg_index           ),
        .cfg_entry    ( cfg_entry           ),
        .lookup_valid ( in_valid            ),
        .dst_addr     ( in_desc.hdr.dst_addr ),
        .result_valid ( lookup_vld          ),
        .result       ( lookup_res          )
    );

    // route result waits for the checksum verdict
    stage_delay #(
        .payload_t ( route_result_t           ),
        .DEPTH     ( VERIFY_LAT - LOOKUP_LAT  )
    ) res_dly (
        .clk       ( clk        ),
        .rst       ( rst        ),
        .in_valid  ( lookup_vld ),
        .in_data   ( lookup_res ),
        .out_valid ( res_vld    ),
        .out_data  ( res_q      )
    );

    ipv4_checksum_verify checksum_verify0 (
        .clk      ( clk         ),
        .rst      ( rst         ),
        .in_valid ( in_valid    ),
        .hdr      ( in_desc.hdr ),
        .ok_valid ( ok_vld      ),
        .hdr_ok   ( hdr_ok      )
    );

    ////////////////////////////////////////////////////////////
    // cycle 1, descriptor and ttl update

    stage_delay #(
        .payload_t ( pkt_desc_t ),
        .DEPTH     ( LOOKUP_LAT )
    ) desc_dly (
        .clk       ( clk      ),
        .rst       ( rst      ),
        .in_valid  ( in_valid ),
        .in_data   ( in_desc  ),
        .out_valid ( desc_vld ),
        .out_data  ( desc_q   )
    );

    // ttl 0 items never forward, no update request
    assign upd_req = desc_vld && (desc_q.hdr.ttl != 8'd0);

    ipv4_checksum_update checksum_update0 (
        .clk          ( clk                                  ),
        .rst          ( rst                                  ),
        .in_valid     ( upd_req                              ),
        .old_checksum ( desc_q.hdr.checksum                  ),
        .ttl_proto    ( {desc_q.hdr.ttl, desc_q.hdr.protocol} ),
        .upd_valid    ( upd_vld                              ),
        .new_checksum ( new_checksum                         )
    );

    ////////////////////////////////////////////////////////////
    // cycle 2 decision, registered out at cycle 3

    forward_ctrl forward_ctrl0 (
        .clk             ( clk             ),
        .rst             ( rst             ),
        .stage_valid     ( desc_vld        ),
        .desc            ( desc_q          ),
        .hdr_ok          ( hdr_ok          ),
        .route           ( res_q           ),
        .new_checksum    ( new_checksum    ),
        .out_valid       ( out_valid       ),
        .out_desc        ( out_desc        ),
        .out_action      ( out_action      ),
        .out_egress_port ( out_egress_port ),
        .drop_counts     ( drop_counts     )
    );

    // all three paths meet forward_ctrl in the same cycle
    a_paths_in_step: assert property (@(posedge clk) disable iff (rst)
        desc_vld |=> (ok_vld && res_vld));

    a_update_in_step: assert property (@(posedge clk) disable iff (rst)
        upd_vld |-> ok_vld);

endmodule

//--- include/fwd_tests.svh
// directed tests and compare tasks for the forwarding stage testbench
// included inside the testbench module, uses its signals, model functions and error counters
`ifndef FWD_TESTS_SVH
`define FWD_TESTS_SVH

////////////////////////////////////////////////////////////
// compare tasks

task automatic check_desc(input string name, input pkt_desc_t exp, input pkt_desc_t act);
    if (act !== exp) begin
        err_value++;
        $display("ERR %s desc expected %h actual %h", name, exp, act);
    end
endtask

task automatic check_action(input string name, input fwd_action_t exp, input fwd_action_t act);
    if (act !== exp) begin
        err_value++;
        $display("ERR %s action expected %s(%0d) actual %s(%0d)",
                 name, exp.name(), exp, act.name(), act);
    end
endtask

task automatic check_port(input string name, input logic [PORT_W-1:0] exp,
                          input logic [PORT_W-1:0] act);
    if (act !== exp) begin
        err_value++;
        $display("ERR %s egress port expected %0d actual %0d", name, exp, act);
    end
endtask

task automatic check_counts(input string name, input drop_counts_t exp, input drop_counts_t act);
    if (act !== exp) begin
        err_value++;
        $display("ERR %s counts expected bad %0d ttl %0d route %0d actual bad %0d ttl %0d route %0d",
                 name, exp.bad_checksum, exp.ttl_expired, exp.no_route,
                 act.bad_checksum, act.ttl_expired, act.no_route);
    end
endtask

task automatic check_cycles(input string name, input int exp, input int act);
    if (act != exp) begin
        err_value++;
        $display("ERR %s latency expected %0d actual %0d", name, exp, act);
    end
endtask

////////////////////////////////////////////////////////////
// stimulus helpers

// table write, model copy follows the dut
task automatic write_route(input int idx, input logic vld, input logic [31:0] prefix,
                           input int len, input int port);
    route_entry_t r;
    r.valid       = vld;
    r.prefix      = prefix;
    r.prefix_len  = 6'(len);
    r.egress_port = PORT_W'(port);
    @(negedge clk);
    cfg_wr    = 1'b1;
    cfg_index = ROUTE_IDX_W'(idx);
    cfg_entry = r;
    @(negedge clk);
    cfg_wr = 1'b0;
    model_tbl[idx] = r;
endtask

// one item in, wait for its output, check everything
task automatic run_item(input string name, input pkt_desc_t d);
    expect_t e;
    int      cycles;
    logic    got;
    e = decide(d);
    @(negedge clk);
    in_valid = 1'b1;
    in_desc  = d;
    cycles   = 0;
    got      = 1'b0;
    while (!got && cycles < PIPE_LAT + 10) begin
        @(negedge clk);
        in_valid = 1'b0;
        cycles++;
        got = out_valid;
    end
    exp_counts = tally(exp_counts, e);
    if (!got) begin
        err_timeout++;
        $display("timeout: %s produced no output", name);
    end else begin
        check_cycles(name, PIPE_LAT, cycles);
        check_desc(name, e.desc, out_desc);
        check_action(name, e.action, out_action);
        check_port(name, e.port, out_egress_port);
        check_counts(name, exp_counts, drop_counts);
    end
endtask

////////////////////////////////////////////////////////////
// directed tests

// empty table after reset
task automatic test_no_route_empty();
    run_item("no_route_empty_0", make_desc(32'h0A01_0203, 8'd64));
    run_item("no_route_empty_1", make_desc(32'hC0A8_0101, 8'd2));
endtask

task automatic test_forward_hit();
    write_route(0, 1'b1, 32'hC0A8_0000, 16, 6);
    run_item("forward_hit_ttl64", make_desc(32'hC0A8_0105, 8'd64));
    // ttl 2 still forwards, leaves with 1
    run_item("forward_hit_ttl2", make_desc(32'hC0A8_FF01, 8'd2));
    run_item("forward_hit_ttl255", make_desc(32'hC0A8_2233, 8'd255));
endtask

task automatic test_longest_prefix();
    write_route(3, 1'b1, 32'h0A00_0000, 8, 3);
    write_route(5, 1'b1, 32'h0A01_0000, 16, 5);
    write_route(7, 1'b1, 32'h0A01_0200, 24, 7);
    // same prefix as entry 7, loses the tie
    write_route(9, 1'b1, 32'h0A01_0200, 24, 9);
    write_route(12, 1'b1, 32'h0000_0000, 0, 12);
    run_item("lpm_len24_tie", make_desc(32'h0A01_0203, 8'd30));
    run_item("lpm_len16", make_desc(32'h0A01_0909, 8'd30));
    run_item("lpm_len8", make_desc(32'h0AC8_0001, 8'd30));
    run_item("lpm_default", make_desc(32'hAC10_0001, 8'd30));
    write_route(7, 1'b1, 32'h0A01_0200, 24, 11);
    run_item("lpm_rewrite_port", make_desc(32'h0A01_0204, 8'd30));
    write_route(7, 1'b0, 32'h0A01_0200, 24, 11);
    run_item("lpm_rewrite_invalid", make_desc(32'h0A01_0205, 8'd30));
endtask

task automatic test_bad_checksum();
    pkt_desc_t d;
    d = make_desc(32'h0A01_0203, 8'd64);
    d.hdr.checksum = d.hdr.checksum ^ 16'h0040;
    run_item("bad_checksum", d);
    // bad checksum wins over ttl 1
    d = make_desc(32'h0A01_0203, 8'd1);
    d.hdr.checksum = d.hdr.checksum ^ 16'h8001;
    run_item("bad_checksum_ttl1", d);
endtask

task automatic test_ttl_punt();
    run_item("ttl_zero", make_desc(32'h0A01_0203, 8'd0));
    run_item("ttl_one", make_desc(32'h0A01_0203, 8'd1));
endtask

task automatic test_no_route_cleared();
    for (int i = 0; i < ROUTE_ENTRIES; i++) begin
        write_route(i, 1'b0, 32'h0, 0, 0);
    end
    run_item("no_route_cleared_0", make_desc(32'h0A01_0203, 8'd64));
    run_item("no_route_cleared_1", make_desc(32'hAC10_0001, 8'd9));
endtask

`endif

//--- verification/ipv4_forward_tb.sv
// testbench for the ipv4 forwarding stage against a reference model
// compiled with all.f from the project root, directed tests come from the included header
`timescale 1ns/100ps

module ipv4_forward_tb;

    import fwd_pkg::*;

    // expected response for one item
    typedef struct packed {
        pkt_desc_t         desc;
        fwd_action_t       action;
        logic [PORT_W-1:0] port;
        logic              is_bad;
        logic              is_ttl;
        logic              is_route;
    } expect_t;

    logic                   clk;
    logic                   rst;
    logic                   in_valid;
    pkt_desc_t              in_desc;
    logic                   cfg_wr;
    logic [ROUTE_IDX_W-1:0] cfg_index;
    route_entry_t           cfg_entry;
    logic                   out_valid;
    pkt_desc_t              out_desc;
    fwd_action_t            out_action;
    logic [PORT_W-1:0]      out_egress_port;
    drop_counts_t           drop_counts;

    route_entry_t           model_tbl [ROUTE_ENTRIES];
    drop_counts_t           exp_counts;
    int                     err_value;
    int                     err_timeout;
    logic [31:0]            lcg_state = 32'd78559;

    ipv4_forward_top dut0 (
        .clk             ( clk             ),
        .rst             ( rst             ),
        .in_valid        ( in_valid        ),
        .in_desc         ( in_desc         ),
        .cfg_wr          ( cfg_wr          ),
        .cfg_index       ( cfg_index       ),
        .cfg_entry       ( cfg_entry       ),
        .out_valid       ( out_valid       ),
        .out_desc        ( out_desc        ),
        .out_action      ( out_action      ),
        .out_egress_port ( out_egress_port ),
        .drop_counts     ( drop_counts     )
    );

    ////////////////////////////////////////////////////////////
    // random source and reference model

    function automatic logic [31:0] rand32();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 15);
    endfunction

    // one's-complement sum of the ten words with carries folded back in
    function automatic logic [15:0] ones_sum(input ipv4_hdr_t h);
        logic [159:0] bits;
        logic [31:0]  acc;
        bits = h;
        acc  = '0;
        for (int i = 0; i < HDR_WORDS; i++) begin
            acc = acc + {16'd0, bits[159 - 16 * i -: 16]};
        end
        while (acc[31:16] != 16'd0) begin
            acc = {16'd0, acc[15:0]} + {16'd0, acc[31:16]};
        end
        return acc[15:0];
    endfunction

    // full recomputation with the checksum field taken as zero
    function automatic logic [15:0] fresh_checksum(input ipv4_hdr_t h);
        h.checksum = 16'd0;
        return ~ones_sum(h);
    endfunction

    function automatic logic prefix_hits(input route_entry_t r, input logic [31:0] dst);
        int sh;
        sh = 32 - int'(r.prefix_len);
        if (!r.valid) begin
            return 1'b0;
        end
        if (r.prefix_len == 6'd0) begin
            return 1'b1;
        end
        return (dst >> sh) == (r.prefix >> sh);
    endfunction

    // longest prefix wins and the lowest index keeps a tie
    function automatic route_result_t lookup_model(input logic [31:0] dst);
        route_result_t rr;
        int            best;
        rr   = '0;
        best = -1;
        for (int i = 0; i < ROUTE_ENTRIES; i++) begin
            if (prefix_hits(model_tbl[i], dst) && int'(model_tbl[i].prefix_len) > best) begin
                best           = int'(model_tbl[i].prefix_len);
                rr.hit         = 1'b1;
                rr.egress_port = model_tbl[i].egress_port;
            end
        end
        return rr;
    endfunction

    function automatic expect_t decide(input pkt_desc_t d);
        expect_t       e;
        route_result_t rr;
        rr     = lookup_model(d.hdr.dst_addr);
        e      = '0;
        e.desc = d;
        if (ones_sum(d.hdr) != 16'hFFFF) begin
            e.action = ACT_DROP;
            e.is_bad = 1'b1;
        end else if (d.hdr.ttl <= 8'd1) begin
            e.action = ACT_TO_CPU;
            e.port   = PORT_W'(CPU_PORT);
            e.is_ttl = 1'b1;
        end else if (!rr.hit) begin
            e.action   = ACT_DROP;
            e.is_route = 1'b1;
        end else begin
            e.action            = ACT_FORWARD;
            e.port              = rr.egress_port;
            e.desc.hdr.ttl      = d.hdr.ttl - 8'd1;
            e.desc.hdr.checksum = fresh_checksum(e.desc.hdr);
        end
        return e;
    endfunction

    function automatic drop_counts_t tally(input drop_counts_t c, input expect_t e);
        if (e.is_bad && !(&c.bad_checksum)) begin
            c.bad_checksum = c.bad_checksum + 1'b1;
        end
        if (e.is_ttl && !(&c.ttl_expired)) begin
            c.ttl_expired = c.ttl_expired + 1'b1;
        end
        if (e.is_route && !(&c.no_route)) begin
            c.no_route = c.no_route + 1'b1;
        end
        return c;
    endfunction

    // random fields around a given destination and ttl with a good checksum
    function automatic pkt_desc_t make_desc(input logic [31:0] dst, input logic [7:0] ttl);
        pkt_desc_t   d;
        logic [31:0] r;
        r                   = rand32();
        d.hdr.version       = 4'd4;
        d.hdr.ihl           = 4'd5;
        d.hdr.tos           = r[7:0];
        d.hdr.total_len     = 16'd20 + {5'd0, r[18:8]};
        d.hdr.flags_frag    = {3'b010, 13'd0};
        d.hdr.ttl           = ttl;
        d.hdr.protocol      = r[26:19];
        r                   = rand32();
        d.hdr.ident         = r[31:16];
        d.hdr.src_addr      = rand32();
        d.hdr.dst_addr      = dst;
        d.hdr.checksum      = 16'd0;
        d.hdr.checksum      = fresh_checksum(d.hdr);
        d.ingress_port      = r[PORT_W-1:0];
        d.byte_length       = d.hdr.total_len;
        return d;
    endfunction

    `include "fwd_tests.svh"

    // 40 items on consecutive cycles while the collector runs alongside
    task automatic test_random_stream();
        pkt_desc_t   d;
        expect_t     q[$];
        expect_t     e;
        logic [31:0] r;
        logic [31:0] dst;
        int          waited;
        logic        got;
        write_route(1, 1'b1, 32'h0A00_0000, 8, 3);
        write_route(2, 1'b1, 32'h0A01_0000, 16, 5);
        write_route(4, 1'b1, 32'hAC10_0000, 12, 8);
        write_route(6, 1'b1, 32'hC0A8_0100, 24, 9);
        write_route(8, 1'b1, 32'hC0A8_014D, 32, 14);
        fork
            begin
                for (int i = 0; i < 40; i++) begin
                    r = rand32();
                    case (r[1:0])
                        2'd0:    dst = {8'h0A, 24'(rand32())};
                        2'd1:    dst = {12'hAC1, 20'(rand32())};
                        2'd2:    dst = {24'hC0A801, 8'(r[15:8] % 8'd80)};
                        default: dst = rand32();
                    endcase
                    d = make_desc(dst, (r[20:18] < 3'd2) ? {5'd0, r[20:18]} : r[31:24] | 8'd2);
                    // about one in five corrupted
                    if (r[7:4] < 4'd3) begin
                        d.hdr.checksum = d.hdr.checksum ^ {r[23:16], r[15:8]} ^ 16'h0101;
                    end
                    @(negedge clk);
                    in_valid = 1'b1;
                    in_desc  = d;
                    q.push_back(decide(d));
                end
                @(negedge clk);
                in_valid = 1'b0;
            end
            begin
                for (int n = 0; n < 40; n++) begin
                    waited = 0;
                    got    = 1'b0;
                    while (!got && waited < PIPE_LAT + 10) begin
                        @(negedge clk);
                        waited++;
                        got = out_valid;
                    end
                    if (!got || q.size() == 0) begin
                        err_timeout++;
                        $display("timeout: random item %0d got no matching output", n);
                        break;
                    end
                    e = q.pop_front();
                    exp_counts = tally(exp_counts, e);
                    check_desc($sformatf("random_%0d", n), e.desc, out_desc);
                    check_action($sformatf("random_%0d", n), e.action, out_action);
                    check_port($sformatf("random_%0d", n), e.port, out_egress_port);
                end
            end
        join
        // nothing may trail the last expected output
        for (int i = 0; i < PIPE_LAT + 4; i++) begin
            @(negedge clk);
            if (out_valid) begin
                err_value++;
                $display("random stream produced an output with no matching input");
            end
        end
        check_counts("random_final", exp_counts, drop_counts);
    endtask

    ////////////////////////////////////////////////////////////
    // clock, reset, sequence

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_desc     = '0;
        cfg_wr      = 1'b0;
        cfg_index   = '0;
        cfg_entry   = '0;
        exp_counts  = '0;
        err_value   = 0;
        err_timeout = 0;
        for (int i = 0; i < ROUTE_ENTRIES; i++) begin
            model_tbl[i] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_no_route_empty();
        test_forward_hit();
        test_longest_prefix();
        test_bad_checksum();
        test_ttl_punt();
        test_no_route_cleared();
        test_random_stream();

        $display("errors: value %0d, timeout %0d", err_value, err_timeout);
        if (err_value == 0 && err_timeout == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+include
rtl/fwd_pkg.sv
rtl/stage_delay.sv
rtl/ipv4_checksum_verify.sv
rtl/ipv4_checksum_update.sv
rtl/route_table.sv
rtl/forward_ctrl.sv
rtl/ipv4_forward_top.sv
verification/ipv4_forward_tb.sv
